/* verilog/ethPkg.sv */
`default_nettype none

package ethPkg;

  typedef logic [3:0]  nibbleT;
  typedef logic [7:0]  byteT;
  typedef logic [31:0] crcT;
  // frames longer than 2047 bytes wrap the count.
  typedef logic [10:0] lenT;

  localparam crcT crcInit  = 32'hffff_ffff;
  localparam crcT crcMagic = 32'hc704_dd7b;

  localparam nibbleT preambleNibble = 4'h5;
  localparam nibbleT sfdNibble      = 4'hd;

  localparam int fifoDepth    = 16;
  localparam int fifoAddrBits = $clog2(fifoDepth);

  typedef enum logic [1:0] {stIdle, stPreamble, stData, stDrop} rxStateT;

endpackage

`default_nettype wire

/* verilog/ethNibbleIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface ethNibbleIf;
  import ethPkg::*;

  nibbleT nibble;
  logic   nibbleValid;
  logic   frameStart;
  logic   frameEnd;
  logic   rxError;

  modport ctrl (output nibble, nibbleValid, frameStart, frameEnd, rxError);
  modport asm (input nibble, nibbleValid, frameStart, frameEnd, rxError);

endinterface

`default_nettype wire

/* verilog/ethCrc.sv */
`timescale 1ns/10ps
`default_nettype none

module ethCrc (
  input  wire logic          Clk,
  input  wire logic          Reset,
  input  wire ethPkg::nibbleT Data,
  input  wire logic          Enable,
  input  wire logic          Initialize,
  output ethPkg::crcT        Crc,
  output logic               CrcError
);
  import ethPkg::*;

  nibbleT t;
  crcT    crcNext;

  // data bit i meets register bit 28+i.
  assign t = Data ^ Crc[31:28];

  always_comb
  begin
    crcNext = {Crc[27:0], 4'h0};
    crcNext[0]  = crcNext[0]  ^ t[0];
    crcNext[1]  = crcNext[1]  ^ t[1] ^ t[0];
    crcNext[2]  = crcNext[2]  ^ t[2] ^ t[1] ^ t[0];
    crcNext[3]  = crcNext[3]  ^ t[3] ^ t[2] ^ t[1];
    crcNext[4]  = crcNext[4]  ^ t[3] ^ t[2] ^ t[0];
    crcNext[5]  = crcNext[5]  ^ t[3] ^ t[1] ^ t[0];
    crcNext[6]  = crcNext[6]  ^ t[2] ^ t[1];
    crcNext[7]  = crcNext[7]  ^ t[3] ^ t[2] ^ t[0];
    crcNext[8]  = crcNext[8]  ^ t[3] ^ t[1] ^ t[0];
    crcNext[9]  = crcNext[9]  ^ t[2] ^ t[1];
    crcNext[10] = crcNext[10] ^ t[3] ^ t[2] ^ t[0];
    crcNext[11] = crcNext[11] ^ t[3] ^ t[1] ^ t[0];
    crcNext[12] = crcNext[12] ^ t[2] ^ t[1] ^ t[0];
    crcNext[13] = crcNext[13] ^ t[3] ^ t[2] ^ t[1];
    crcNext[14] = crcNext[14] ^ t[3] ^ t[2];
    crcNext[15] = crcNext[15] ^ t[3];
    crcNext[16] = crcNext[16] ^ t[0];
    crcNext[17] = crcNext[17] ^ t[1];
    crcNext[18] = crcNext[18] ^ t[2];
    crcNext[19] = crcNext[19] ^ t[3];
    crcNext[22] = crcNext[22] ^ t[0];
    crcNext[23] = crcNext[23] ^ t[1] ^ t[0];
    crcNext[24] = crcNext[24] ^ t[2] ^ t[1];
    crcNext[25] = crcNext[25] ^ t[3] ^ t[2];
    crcNext[26] = crcNext[26] ^ t[3] ^ t[0];
    crcNext[27] = crcNext[27] ^ t[1];
    crcNext[28] = crcNext[28] ^ t[2];
    crcNext[29] = crcNext[29] ^ t[3];
  end

  always_ff @(posedge Clk or posedge Reset)
  begin
    if (Reset)
      Crc <= crcInit;
    else if (Initialize)
      Crc <= crcInit;
    else if (Enable)
      Crc <= crcNext;
  end

  // residue of a good frame including its FCS.
  assign CrcError = Crc != crcMagic;

  // the preset comes from frameStart, one cycle ahead of the first nibble.
  initEnableExclusive: assert property (@(posedge Clk) disable iff (Reset)
    !(Initialize && Enable));

endmodule

`default_nettype wire

/* verilog/ethRxCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module ethRxCtrl (
  input  wire logic           Clk,
  input  wire logic           Reset,
  input  wire ethPkg::nibbleT RxData,
  input  wire logic           RxDv,
  input  wire logic           RxEr,
  ethNibbleIf.ctrl            nib
);
  import ethPkg::*;

  rxStateT state;
  nibbleT  rxDataQ;
  logic    rxDvQ;
  logic    rxErQ;

  always_ff @(posedge Clk)
  begin
    rxDataQ <= RxData;
    if (state == stData && rxDvQ)
      nib.nibble <= rxDataQ;
  end

  always_ff @(posedge Clk or posedge Reset)
  begin
    if (Reset)
    begin
      rxDvQ           <= 1'b0;
      rxErQ           <= 1'b0;
      state           <= stIdle;
      nib.nibbleValid <= 1'b0;
      nib.frameStart  <= 1'b0;
      nib.frameEnd    <= 1'b0;
      nib.rxError     <= 1'b0;
    end
    else
    begin
      rxDvQ           <= RxDv;
      rxErQ           <= RxEr;
      nib.nibbleValid <= 1'b0;
      nib.frameStart  <= 1'b0;
      nib.frameEnd    <= 1'b0;
      // error flag lives until the frame end has been seen.
      if (nib.frameEnd)
        nib.rxError <= 1'b0;
      case (state)
        stIdle:
          if (rxDvQ && rxDataQ == preambleNibble)
            state <= stPreamble;
        stPreamble:
          if (!rxDvQ)
            state <= stIdle;
          else if (rxDataQ == sfdNibble)
          begin
            state          <= stData;
            nib.frameStart <= 1'b1;
          end
          else if (rxDataQ != preambleNibble)
            state <= stDrop;
        stData:
          if (rxDvQ)
          begin
            nib.nibbleValid <= 1'b1;
            if (rxErQ)
              nib.rxError <= 1'b1;
          end
          else
          begin
            state        <= stIdle;
            nib.frameEnd <= 1'b1;
          end
        stDrop:
          if (!rxDvQ)
            state <= stIdle;
        default:
          state <= stIdle;
      endcase
    end
  end

  // a forwarded nibble was on the MII pins two edges earlier.
  validInData: assert property (@(posedge Clk) disable iff (Reset)
    nib.nibbleValid |-> state == stData && $past(RxDv, 2) &&
                        nib.nibble == $past(RxData, 2));

endmodule

`default_nettype wire

/* verilog/ethRxAssembler.sv */
`timescale 1ns/10ps
`default_nettype none

module ethRxAssembler (
  input  wire logic Clk,
  input  wire logic Reset,
  ethNibbleIf.asm   nib,
  input  wire logic fifoFull,
  output ethPkg::byteT WrData,
  output logic      WrLast,
  output logic      WrEn,
  output logic      StatusValid,
  output logic      StatusCrcOk,
  output ethPkg::lenT StatusLength,
  output logic      StatusDribble,
  output logic      StatusRxError,
  output logic      StatusOverflow
);
  import ethPkg::*;

  nibbleT lowNib;
  byteT   holdByte;
  logic   haveLow;
  logic   holdValid;
  lenT    byteCount;
  logic   overflow;
  logic   crcError;

  // the CRC block wants the MII nibble bit reversed.
  ethCrc crc (
    .Clk        (Clk),
    .Reset      (Reset),
    .Data       ({nib.nibble[0], nib.nibble[1], nib.nibble[2], nib.nibble[3]}),
    .Enable     (nib.nibbleValid),
    .Initialize (nib.frameStart),
    .Crc        (),
    .CrcError   (crcError)
  );

  // held byte leaves when the next byte completes, or tagged last at frame end.
  assign WrEn   = holdValid && ((nib.nibbleValid && haveLow) || nib.frameEnd);
  assign WrData = holdByte;
  assign WrLast = nib.frameEnd;

  always_ff @(posedge Clk or posedge Reset)
  begin
    if (Reset)
    begin
      haveLow     <= 1'b0;
      holdValid   <= 1'b0;
      byteCount   <= '0;
      overflow    <= 1'b0;
      StatusValid <= 1'b0;
    end
    else
    begin
      StatusValid <= nib.frameEnd;
      if (nib.frameStart)
      begin
        haveLow   <= 1'b0;
        holdValid <= 1'b0;
        byteCount <= '0;
        overflow  <= 1'b0;
      end
      else
      begin
        if (nib.nibbleValid)
        begin
          haveLow <= !haveLow;
          if (haveLow)
          begin
            holdValid <= 1'b1;
            byteCount <= byteCount + 1'b1;
          end
        end
        else if (nib.frameEnd)
        begin
          haveLow   <= 1'b0;
          holdValid <= 1'b0;
        end
        if (WrEn && fifoFull)
          overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge Clk)
  begin
    if (nib.nibbleValid)
    begin
      if (haveLow)
        holdByte <= {nib.nibble, lowNib};
      else
        lowNib <= nib.nibble;
    end
    if (nib.frameEnd)
    begin
      StatusCrcOk    <= !crcError;
      StatusLength   <= byteCount;
      StatusDribble  <= haveLow;
      StatusRxError  <= nib.rxError;
      StatusOverflow <= overflow || (WrEn && fifoFull);
    end
  end

  statusPulse: assert property (@(posedge Clk) disable iff (Reset)
    StatusValid |=> !StatusValid);

endmodule

`default_nettype wire

/* verilog/ethRxFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module ethRxFifo (
  input  wire logic         Clk,
  input  wire logic         Reset,
  input  wire ethPkg::byteT WrData,
  input  wire logic         WrLast,
  input  wire logic         WrEn,
  output logic              Full,
  output ethPkg::byteT      OutData,
  output logic              OutLast,
  output logic              OutValid,
  input  wire logic         OutReady
);
  import ethPkg::*;

  // each entry is the last marker above the byte.
  logic [$bits(byteT):0] mem [fifoDepth];
  logic [fifoAddrBits:0] wrPtr;
  logic [fifoAddrBits:0] rdPtr;

  assign OutValid = wrPtr != rdPtr;
  assign Full     = (wrPtr[fifoAddrBits] != rdPtr[fifoAddrBits]) &&
                    (wrPtr[fifoAddrBits-1:0] == rdPtr[fifoAddrBits-1:0]);
  assign {OutLast, OutData} = mem[rdPtr[fifoAddrBits-1:0]];

  always_ff @(posedge Clk)
  begin
    if (WrEn && !Full)
      mem[wrPtr[fifoAddrBits-1:0]] <= {WrLast, WrData};
  end

  always_ff @(posedge Clk or posedge Reset)
  begin
    if (Reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (WrEn && !Full)
        wrPtr <= wrPtr + 1'b1;
      if (OutValid && OutReady)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  outputHolds: assert property (@(posedge Clk) disable iff (Reset)
    OutValid && !OutReady |=> OutValid && $stable(OutData) && $stable(OutLast));

endmodule

`default_nettype wire

/* verilog/ethRx.sv */
`timescale 1ns/10ps
`default_nettype none

module ethRx (
  input  wire logic           Clk,
  input  wire logic           Reset,
  input  wire ethPkg::nibbleT RxData,
  input  wire logic           RxDv,
  input  wire logic           RxEr,
  output ethPkg::byteT        OutData,
  output logic                OutLast,
  output logic                OutValid,
  input  wire logic           OutReady,
  output logic                StatusValid,
  output logic                StatusCrcOk,
  output ethPkg::lenT         StatusLength,
  output logic                StatusDribble,
  output logic                StatusRxError,
  output logic                StatusOverflow
);
  import ethPkg::*;

  byteT wrData;
  logic wrLast;
  logic wrEn;
  logic fifoFull;

  ethNibbleIf nib ();

  ethRxCtrl ctrl (
    .Clk    (Clk),
    .Reset  (Reset),
    .RxData (RxData),
    .RxDv   (RxDv),
    .RxEr   (RxEr),
    .nib    (nib.ctrl)
  );

  ethRxAssembler assembler (
    .Clk            (Clk),
    .Reset          (Reset),
    .nib            (nib.asm),
    .fifoFull       (fifoFull),
    .WrData         (wrData),
    .WrLast         (wrLast),
    .WrEn           (wrEn),
    .StatusValid    (StatusValid),
    .StatusCrcOk    (StatusCrcOk),
    .StatusLength   (StatusLength),
    .StatusDribble  (StatusDribble),
    .StatusRxError  (StatusRxError),
    .StatusOverflow (StatusOverflow)
  );

  ethRxFifo fifo (
    .Clk      (Clk),
    .Reset    (Reset),
    .WrData   (wrData),
    .WrLast   (wrLast),
    .WrEn     (wrEn),
    .Full     (fifoFull),
    .OutData  (OutData),
    .OutLast  (OutLast),
    .OutValid (OutValid),
    .OutReady (OutReady)
  );

endmodule

`default_nettype wire

/* testbench/ethRxChecker.sv */
`timescale 1ns/10ps
`default_nettype none

module ethRxChecker (
  input wire logic         Clk,
  input wire logic         Reset,
  input wire ethPkg::byteT OutData,
  input wire logic         OutLast,
  input wire logic         OutValid,
  input wire logic         OutReady,
  input wire logic         StatusValid,
  input wire logic         StatusCrcOk,
  input wire ethPkg::lenT  StatusLength,
  input wire logic         StatusDribble,
  input wire logic         StatusRxError,
  input wire logic         StatusOverflow
);
  import ethPkg::*;

  // byte entries are {last, data}.
  logic [8:0]  expBytes [$];
  // status entries are {crcOk, length, dribble, rxError, overflow}.
  logic [14:0] expStatus [$];

  int          byteErrors = 0;
  int          statusErrors = 0;
  logic [8:0]  wantByte;
  logic [14:0] wantStatus;

  task automatic compareField(input string name, input int got, input int want);
    if (got != want)
    begin
      $display("[ERROR] %0t: status %s is %0d, expected %0d", $time, name, got, want);
      statusErrors++;
    end
  endtask

  // outputs change only after the edge, so the values seen here are the ones that transfer.
  always @(posedge Clk)
  begin
    if (!Reset && OutValid && OutReady)
    begin
      if (expBytes.size() == 0)
      begin
        $display("an output byte %h came out at %0t when no byte was expected", OutData, $time);
        byteErrors++;
      end
      else
      begin
        wantByte = expBytes.pop_front();
        if (OutData != wantByte[7:0] || OutLast != wantByte[8])
        begin
          $display("[ERROR] %0t: byte %h last %b, expected %h last %b",
                   $time, OutData, OutLast, wantByte[7:0], wantByte[8]);
          byteErrors++;
        end
      end
    end
  end

  always @(posedge Clk)
  begin
    if (!Reset && StatusValid)
    begin
      if (expStatus.size() == 0)
      begin
        $display("a frame status came out at %0t when no frame was expected", $time);
        statusErrors++;
      end
      else
      begin
        wantStatus = expStatus.pop_front();
        compareField("crcOk", StatusCrcOk, wantStatus[14]);
        compareField("length", StatusLength, wantStatus[13:3]);
        compareField("dribble", StatusDribble, wantStatus[2]);
        compareField("rxError", StatusRxError, wantStatus[1]);
        compareField("overflow", StatusOverflow, wantStatus[0]);
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tbEthRx.sv */
`timescale 1ns/10ps
`default_nettype none

module tbEthRx;
  import ethPkg::*;

  localparam int modeNormal      = 0;
  localparam int modeBadPreamble = 1;
  localparam int modeRxError     = 2;
  localparam int modeOddNibble   = 3;
  localparam int modeStall       = 4;

  logic   Clk;
  logic   Reset;
  nibbleT RxData;
  logic   RxDv;
  logic   RxEr;
  byteT   OutData;
  logic   OutLast;
  logic   OutValid;
  logic   OutReady;
  logic   StatusValid;
  logic   StatusCrcOk;
  lenT    StatusLength;
  logic   StatusDribble;
  logic   StatusRxError;
  logic   StatusOverflow;

  integer seed = 22831;
  logic   stallReady;
  logic   loaded;
  longint limitNs = 0;

  int   frameMode [$];
  int   frameArg [$];
  logic frameCrcOk [$];
  int   frameFirst [$];
  int   frameLen [$];
  byteT frameBytes [$];

  ethRx dut (
    .Clk            (Clk),
    .Reset          (Reset),
    .RxData         (RxData),
    .RxDv           (RxDv),
    .RxEr           (RxEr),
    .OutData        (OutData),
    .OutLast        (OutLast),
    .OutValid       (OutValid),
    .OutReady       (OutReady),
    .StatusValid    (StatusValid),
    .StatusCrcOk    (StatusCrcOk),
    .StatusLength   (StatusLength),
    .StatusDribble  (StatusDribble),
    .StatusRxError  (StatusRxError),
    .StatusOverflow (StatusOverflow)
  );

  ethRxChecker monitor (
    .Clk            (Clk),
    .Reset          (Reset),
    .OutData        (OutData),
    .OutLast        (OutLast),
    .OutValid       (OutValid),
    .OutReady       (OutReady),
    .StatusValid    (StatusValid),
    .StatusCrcOk    (StatusCrcOk),
    .StatusLength   (StatusLength),
    .StatusDribble  (StatusDribble),
    .StatusRxError  (StatusRxError),
    .StatusOverflow (StatusOverflow)
  );

  initial
  begin
    Clk = 1'b0;
    forever #50 Clk = !Clk;
  end

  function automatic int modeCode(input logic [8*16-1:0] word);
    if (word == "normal")
      return modeNormal;
    if (word == "badPreamble")
      return modeBadPreamble;
    if (word == "rxErrorAt")
      return modeRxError;
    if (word == "oddNibble")
      return modeOddNibble;
    if (word == "stall")
      return modeStall;
    return -1;
  endfunction

  task automatic loadTests(output logic ok);
    integer           fd;
    integer           code;
    logic [8*16-1:0]  word;
    logic [8*160-1:0] rest;
    int               arg;
    int               crcOk;
    int               count;
    int               value;
    int               nibbles;
    int               i;
    ok = 1'b0;
    nibbles = 0;
    fd = $fopen("testbench/ethRxTests.txt", "r");
    if (fd == 0)
      $display("the test file testbench/ethRxTests.txt could not be opened");
    else
    begin
      ok = 1'b1;
      while (!$feof(fd))
      begin
        code = $fscanf(fd, "%s", word);
        if (code == 1 && word == "#")
          code = $fgets(rest, fd);
        else if (code == 1)
        begin
          code = $fscanf(fd, "%d %d %d", arg, crcOk, count);
          if (modeCode(word) < 0)
          begin
            $display("the test file holds an unknown mode %0s", word);
            ok = 1'b0;
          end
          frameMode.push_back(modeCode(word));
          frameArg.push_back(arg);
          frameCrcOk.push_back(crcOk != 0);
          frameFirst.push_back(frameBytes.size());
          frameLen.push_back(count);
          for (i = 0; i < count; i++)
          begin
            code = $fscanf(fd, "%h", value);
            frameBytes.push_back(byteT'(value));
          end
          // preamble and delimiter are eight nibbles.
          nibbles += 8 + 2 * count + ((modeCode(word) == modeOddNibble) ? 1 : 0);
        end
      end
      $fclose(fd);
      limitNs = (longint'(nibbles) + 40 * frameMode.size()) * 100 + 2000;
    end
  endtask

  // one clock of MII input, with the output ready chosen for the same edge.
  task automatic driveCycle(input nibbleT data, input logic dv, input logic er);
    logic [31:0] rnd;
    @(negedge Clk);
    rnd = $random(seed);
    RxData   = data;
    RxDv     = dv;
    RxEr     = er;
    OutReady = !stallReady && (rnd[1:0] != 2'b00);
  endtask

  task automatic expectFrame(input int f);
    int   i;
    int   kept;
    logic overflow;
    logic odd;
    logic rxErr;
    if (frameMode[f] != modeBadPreamble)
    begin
      overflow = frameMode[f] == modeStall && frameLen[f] > fifoDepth;
      odd      = frameMode[f] == modeOddNibble;
      rxErr    = frameMode[f] == modeRxError;
      // a full FIFO keeps only the first fifoDepth bytes, so the last marker is lost.
      kept = overflow ? fifoDepth : frameLen[f];
      for (i = 0; i < kept; i++)
        monitor.expBytes.push_back({!overflow && i == frameLen[f] - 1,
                                    frameBytes[frameFirst[f] + i]});
      monitor.expStatus.push_back({frameCrcOk[f], lenT'(frameLen[f]), odd, rxErr, overflow});
    end
  endtask

  task automatic sendFrame(input int f);
    int          i;
    byteT        b;
    nibbleT      n;
    logic [31:0] rnd;
    for (i = 0; i < 7; i++)
    begin
      if (frameMode[f] == modeBadPreamble && i == frameArg[f])
        driveCycle(4'h7, 1'b1, 1'b0);
      else
        driveCycle(4'h5, 1'b1, 1'b0);
    end
    driveCycle(4'hd, 1'b1, 1'b0);
    for (i = 0; i < 2 * frameLen[f]; i++)
    begin
      b = frameBytes[frameFirst[f] + i / 2];
      n = (i % 2 == 0) ? b[3:0] : b[7:4];
      driveCycle(n, 1'b1, frameMode[f] == modeRxError && i == frameArg[f]);
    end
    if (frameMode[f] == modeOddNibble)
    begin
      rnd = $random(seed);
      driveCycle(rnd[3:0], 1'b1, 1'b0);
    end
  endtask

  task automatic runTests();
    int f;
    for (f = 0; f < frameMode.size(); f++)
    begin
      // a stalled frame starts from an empty FIFO.
      if (frameMode[f] == modeStall)
        while (OutValid || monitor.expBytes.size() != 0)
          driveCycle(4'h0, 1'b0, 1'b0);
      expectFrame(f);
      stallReady = frameMode[f] == modeStall;
      sendFrame(f);
      repeat (12) driveCycle(4'h0, 1'b0, 1'b0);
      stallReady = 1'b0;
      if (frameMode[f] == modeStall)
        while (OutValid || monitor.expBytes.size() != 0)
          driveCycle(4'h0, 1'b0, 1'b0);
    end
    while (monitor.expBytes.size() != 0 || monitor.expStatus.size() != 0)
      driveCycle(4'h0, 1'b0, 1'b0);
    repeat (10) driveCycle(4'h0, 1'b0, 1'b0);
  endtask

  initial
  begin
    Reset      = 1'b1;
    RxData     = 4'h0;
    RxDv       = 1'b0;
    RxEr       = 1'b0;
    OutReady   = 1'b0;
    stallReady = 1'b0;
    loadTests(loaded);
    if (!loaded)
    begin
      $display("the run stopped because the test file could not be read");
      $display("FAIL: see errors above");
      $finish;
    end
    else
    begin
      repeat (16) @(negedge Clk);
      Reset = 1'b0;
      runTests();
      $display("frames: %0d, byte errors: %0d, status errors: %0d",
               frameMode.size(), monitor.byteErrors, monitor.statusErrors);
      if (monitor.byteErrors + monitor.statusErrors == 0)
        $display("PASS: all tests");
      else
        $display("FAIL: see errors above");
      $finish;
    end
  end

  initial
  begin
    wait (limitNs > 0);
    #(limitNs);
    $display("the simulation timed out waiting for output");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/ethRxTests.txt */
# mode arg crcOk count, then count frame bytes in hex, FCS last with its low byte first
# arg is the bad preamble position for badPreamble and the data nibble index for rxErrorAt
# a frame's bytes may run on over the next line
normal      0 1 13 31 32 33 34 35 36 37 38 39 26 39 f4 cb
normal      0 1  7 61 62 63 c2 41 24 35
normal      0 0  7 61 62 63 c2 41 24 36
badPreamble 3 1  5 61 43 be b7 e8
normal      0 1  5 61 43 be b7 e8
oddNibble   0 0 13 31 32 33 34 35 36 37 38 39 26 39 f4 cb
rxErrorAt   5 1  7 61 62 63 c2 41 24 35
normal      0 1  4 00 00 00 00
stall       0 1 47 54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20 66 6f 78 20 6a 75 6d 70
                   73 20 6f 76 65 72 20 74 68 65 20 6c 61 7a 79 20 64 6f 67 39 a3 4f 41
normal      0 1 13 31 32 33 34 35 36 37 38 39 26 39 f4 cb
stall       0 1  7 61 62 63 c2 41 24 35
normal      0 1  5 61 43 be b7 e8

/* sim.f */
verilog/ethPkg.sv
verilog/ethNibbleIf.sv
verilog/ethCrc.sv
verilog/ethRxCtrl.sv
verilog/ethRxAssembler.sv
verilog/ethRxFifo.sv
verilog/ethRx.sv
testbench/ethRxChecker.sv
testbench/tbEthRx.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tbEthRx -o tbEthRx

status=0
./obj_dir/tbEthRx > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
